//--- source/prng_pkg.sv
/* prng shared definitions */

package prng_pkg;

  ////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////

  // axi4-lite bus widths
  localparam int unsigned AXIL_ADDR_W = 8;
  localparam int unsigned AXIL_DATA_W = 32;

  // one random word as buffered and returned on a data read
  localparam int unsigned WORD_W = 16;

  // word buffer depth and fill count width
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned FIFO_CNT_W = 4;

  // reset and lockup reseed value, must be nonzero
  localparam logic [31:0] DEFAULT_SEED = 32'd1;

  typedef logic [WORD_W-1:0] rand_word_t;

  ////////////////////////////////////////////////
  // register map and bus responses
  ////////////////////////////////////////////////

  typedef enum logic [AXIL_ADDR_W-1:0] {
    REG_CTRL    = 8'h00,
    REG_SEED    = 8'h04,
    REG_ENTROPY = 8'h08,
    REG_DATA    = 8'h0C,
    REG_STATUS  = 8'h10
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // control bundle from the register block to the stepper
  typedef struct packed {
    logic                   run;
    logic                   seed_load;
    logic [AXIL_DATA_W-1:0] seed;
    logic                   entropy_valid;
    logic [AXIL_DATA_W-2:0] entropy;
  } lfsr_ctrl_t;

  // galois tap masks for the supported state widths
  function automatic logic [31:0] lfsr_coeffs(input int unsigned width);
    case (width)
      16:      return 32'h0000_D008;
      24:      return 32'h00E1_0000;
      32:      return 32'h8020_0003;
      default: return 32'h0000_0000;
    endcase
  endfunction

endpackage

//--- source/lfsr_stepper.sv
/* galois lfsr stepper */

`timescale 1ns/1ps

module lfsr_stepper import prng_pkg::*; #(
  parameter int unsigned LfsrW = 32
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  lfsr_ctrl_t ctrl_i,
  output logic       push_valid_o,
  input  logic       push_ready_i,
  output rand_word_t push_word_o
);

  // tap mask and reseed value cut to the state width
  localparam logic [LfsrW-1:0] Coeffs   = LfsrW'(lfsr_coeffs(LfsrW));
  localparam logic [LfsrW-1:0] ResetVal = LfsrW'(DEFAULT_SEED);

  logic [LfsrW-1:0] state_q;
  logic [LfsrW-1:0] state_d;
  logic [LfsrW-1:0] next_state;
  logic [LfsrW-1:0] entropy_q;
  logic [LfsrW-1:0] entropy_mix;
  logic             entropy_pend_q;
  logic             lockup;
  logic             step;

  // a word is offered whenever running and no seed is going in
  assign push_valid_o = ctrl_i.run && !ctrl_i.seed_load;
  assign step         = push_valid_o && push_ready_i;

  // low-order state tap
  assign push_word_o = state_q[WORD_W-1:0];

  // all-zero state never leaves on its own
  assign lockup = ~(|state_q);

  // pending entropy is mixed in exactly once
  assign entropy_mix = entropy_pend_q ? entropy_q : '0;

  // shift right, fold taps back in on a set low bit, then xor entropy
  assign next_state = (state_q >> 1) ^ ({LfsrW{state_q[0]}} & Coeffs) ^ entropy_mix;

  // seed load wins over stepping
  always_comb begin
    state_d = state_q;
    if (ctrl_i.seed_load) begin
      state_d = LfsrW'(ctrl_i.seed);
    end else if (step && lockup) begin
      state_d = ResetVal;
    end else if (step) begin
      state_d = next_state;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= ResetVal;
      entropy_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // a fresh entropy write stays pending even if a step uses the old one
      if (ctrl_i.entropy_valid) begin
        entropy_pend_q <= 1'b1;
      end else if (step) begin
        entropy_pend_q <= 1'b0;
      end
    end
  end

  // entropy payload, only looked at while pending
  always_ff @(posedge clk_i) begin
    if (ctrl_i.entropy_valid) begin
      entropy_q <= LfsrW'(ctrl_i.entropy);
    end
  end

endmodule

//--- source/word_fifo.sv
/* random word fifo */

`timescale 1ns/1ps

module word_fifo import prng_pkg::*; #(
  parameter int unsigned FifoDepth = FIFO_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  rand_word_t            push_word_i,
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output rand_word_t            pop_word_o,
  output logic [FIFO_CNT_W-1:0] count_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  rand_word_t            mem_q [FifoDepth];
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  push;
  logic                  pop;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // back-pressure to the stepper when full
  assign push_ready_o = (count_q != FIFO_CNT_W'(FifoDepth));
  assign pop_valid_o  = (count_q != '0);

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // head word, one cycle after its push
  assign pop_word_o = mem_q[rd_ptr_q];
  assign count_o    = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

endmodule

//--- source/axil_prng_regs.sv
/* axi4-lite prng registers */

`timescale 1ns/1ps

module axil_prng_regs import prng_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // write address and data
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  reg_addr_e              awaddr_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  // write response
  output logic                   bvalid_o,
  input  logic                   bready_i,
  output axil_resp_e             bresp_o,
  // read address and data
  input  logic                   arvalid_i,
  output logic                   arready_o,
  input  reg_addr_e              araddr_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output axil_resp_e             rresp_o,
  // to the stepper
  output lfsr_ctrl_t             ctrl_o,
  // from the word fifo
  input  logic                   pop_valid_i,
  output logic                   pop_ready_o,
  input  rand_word_t             pop_word_i,
  input  logic [FIFO_CNT_W-1:0]  count_i
);

  typedef enum logic [1:0] {W_IDLE, W_HOLD, W_RESP} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_HOLD, R_RESP} rd_state_e;

  wr_state_e              w_state_q;
  rd_state_e              r_state_q;
  logic                   awready_q;
  logic                   wready_q;
  logic                   aw_got_q;
  logic                   w_got_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   aw_have;
  logic                   w_have;
  logic                   ar_hs;
  reg_addr_e              awaddr_q;
  logic [AXIL_DATA_W-1:0] wdata_q;
  logic                   run_q;
  logic [AXIL_DATA_W-1:0] rdata_d;
  logic [AXIL_DATA_W-1:0] rdata_q;
  axil_resp_e             rresp_d;
  axil_resp_e             rresp_q;

  ////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////

  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  assign aw_hs     = awvalid_i && awready_o;
  assign w_hs      = wvalid_i && wready_o;

  // address and data may come in either order
  assign aw_have = aw_got_q || aw_hs;
  assign w_have  = w_got_q || w_hs;

  assign bvalid_o = (w_state_q == W_RESP);
  // every write is acknowledged, unmapped ones are dropped
  assign bresp_o  = RESP_OKAY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      run_q     <= 1'b0;
    end else begin
      case (w_state_q)
        W_IDLE: begin
          aw_got_q  <= aw_have;
          w_got_q   <= w_have;
          // readies come up after reset and drop once their beat is in
          awready_q <= !aw_have;
          wready_q  <= !w_have;
          if (aw_have && w_have) begin
            w_state_q <= W_HOLD;
          end
        end
        W_HOLD: begin
          // register update, stepper pulses are out this cycle
          if (awaddr_q == REG_CTRL) begin
            run_q <= wdata_q[0];
          end
          w_state_q <= W_RESP;
        end
        W_RESP: begin
          if (bready_i) begin
            w_state_q <= W_IDLE;
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
          end
        end
        default: w_state_q <= W_IDLE;
      endcase
    end
  end

  // write payload
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awaddr_q <= awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
    end
  end

  // seed and entropy pulses in the hold cycle, run as a level
  always_comb begin
    ctrl_o.run           = run_q;
    ctrl_o.seed_load     = (w_state_q == W_HOLD) && (awaddr_q == REG_SEED);
    ctrl_o.seed          = wdata_q;
    ctrl_o.entropy_valid = (w_state_q == W_HOLD) && (awaddr_q == REG_ENTROPY);
    ctrl_o.entropy       = wdata_q[AXIL_DATA_W-2:0];
  end

  ////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////

  // arready held high in R_HOLD until an address turns up
  assign arready_o = (r_state_q == R_HOLD);
  assign ar_hs     = arvalid_i && arready_o;
  assign rvalid_o  = (r_state_q == R_RESP);
  assign rdata_o   = rdata_q;
  assign rresp_o   = rresp_q;

  // response formed on the handshake cycle, fifo popped right here
  always_comb begin
    rdata_d     = '0;
    rresp_d     = RESP_OKAY;
    pop_ready_o = 1'b0;
    case (araddr_i)
      REG_CTRL:   rdata_d = AXIL_DATA_W'(run_q);
      REG_STATUS: rdata_d = AXIL_DATA_W'(count_i);
      REG_DATA: begin
        if (pop_valid_i) begin
          rdata_d     = AXIL_DATA_W'(pop_word_i);
          pop_ready_o = ar_hs;
        end else begin
          // empty buffer
          rresp_d = RESP_SLVERR;
        end
      end
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_state_q <= R_IDLE;
    end else begin
      case (r_state_q)
        R_IDLE:  r_state_q <= R_HOLD;
        R_HOLD:  r_state_q <= ar_hs ? R_RESP : R_HOLD;
        R_RESP:  r_state_q <= rready_i ? R_IDLE : R_RESP;
        default: r_state_q <= R_IDLE;
      endcase
    end
  end

  // read payload holds while rready is low
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

endmodule

//--- source/prng_top.sv
/* prng top level */

`timescale 1ns/1ps

module prng_top import prng_pkg::*; #(
  parameter int unsigned LfsrW     = 32,
  parameter int unsigned FifoDepth = FIFO_DEPTH
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // axi4-lite slave
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  reg_addr_e              awaddr_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  logic [AXIL_DATA_W-1:0] wdata_i,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  output axil_resp_e             bresp_o,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  input  reg_addr_e              araddr_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output logic [AXIL_DATA_W-1:0] rdata_o,
  output axil_resp_e             rresp_o
);

  lfsr_ctrl_t            ctrl;
  logic                  push_valid;
  logic                  push_ready;
  rand_word_t            push_word;
  logic                  pop_valid;
  logic                  pop_ready;
  rand_word_t            pop_word;
  logic [FIFO_CNT_W-1:0] count;

  // bus front end, drains the buffer
  axil_prng_regs i_regs (
    .clk_i, .rst_ni,
    .awvalid_i, .awready_o, .awaddr_i,
    .wvalid_i, .wready_o, .wdata_i,
    .bvalid_o, .bready_i, .bresp_o,
    .arvalid_i, .arready_o, .araddr_i,
    .rvalid_o, .rready_i, .rdata_o, .rresp_o,
    .ctrl_o      (ctrl),
    .pop_valid_i (pop_valid),
    .pop_ready_o (pop_ready),
    .pop_word_i  (pop_word),
    .count_i     (count)
  );

  // word producer
  lfsr_stepper #(.LfsrW(LfsrW)) i_stepper (
    .clk_i, .rst_ni,
    .ctrl_i       (ctrl),
    .push_valid_o (push_valid),
    .push_ready_i (push_ready),
    .push_word_o  (push_word)
  );

  // buffer between the two
  word_fifo #(.FifoDepth(FifoDepth)) i_fifo (
    .clk_i, .rst_ni,
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .push_word_i  (push_word),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (pop_ready),
    .pop_word_o   (pop_word),
    .count_o      (count)
  );

endmodule

//--- testbench/tb_prng_top.sv
/* prng testbench */

`timescale 1ns/1ps

module tb_prng_top import prng_pkg::*; ();

  // handshake wait limit in cycles
  localparam int unsigned TIMEOUT   = 100;
  // status polls before giving up
  localparam int unsigned MAX_POLLS = 50;
  // galois taps for the 32-bit default width
  localparam logic [31:0] TAPS      = 32'h8020_0003;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_FILL, OP_DRAIN} op_e;

  // one table row of operation, register, data or expected word and expected response
  typedef struct packed {
    op_e                    op;
    reg_addr_e              addr;
    logic [AXIL_DATA_W-1:0] data;
    axil_resp_e             resp;
  } step_t;

  logic                   clk;
  logic                   rst_n;
  logic                   awvalid;
  logic                   awready;
  reg_addr_e              awaddr;
  logic                   wvalid;
  logic                   wready;
  logic [AXIL_DATA_W-1:0] wdata;
  logic                   bvalid;
  logic                   bready;
  axil_resp_e             bresp;
  logic                   arvalid;
  logic                   arready;
  reg_addr_e              araddr;
  logic                   rvalid;
  logic                   rready;
  logic [AXIL_DATA_W-1:0] rdata;
  axil_resp_e             rresp;

  step_t       steps [$];
  logic [31:0] model_state;
  logic [31:0] model_ent;
  logic        model_pend;

  prng_top i_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  // 4 ns period
  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input rand_word_t exp, input rand_word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_count(input string name, input logic [FIFO_CNT_W-1:0] exp,
                             input logic [FIFO_CNT_W-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // reference lfsr model
  //////////////////////////////////////////////////

  // shift right, taps on a set low bit, xor entropy; zero state reseeds
  function automatic logic [31:0] galois_next(input logic [31:0] s, input logic [31:0] ent);
    if (s == '0) begin
      return DEFAULT_SEED;
    end
    return (s >> 1) ^ (s[0] ? TAPS : 32'h0) ^ ent;
  endfunction

  // word of the current state, then one step with any pending entropy
  task automatic model_advance(output rand_word_t word);
    word        = model_state[WORD_W-1:0];
    model_state = galois_next(model_state, model_pend ? model_ent : 32'h0);
    model_pend  = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // axi4-lite driver
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic axil_write(input reg_addr_e addr, input logic [31:0] data,
                            output axil_resp_e resp);
    int unsigned waited;
    logic        aw_fire;
    logic        w_fire;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    waited  = 0;
    // address and data beats may be taken on different edges
    while (awvalid || wvalid) begin
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      next_cycle();
      if (aw_fire) awvalid = 1'b0;
      if (w_fire) wvalid = 1'b0;
      waited++;
      if (waited > TIMEOUT) stop_on_error("write address or data was never accepted");
    end
    waited = 0;
    while (!bvalid) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_on_error("no write response arrived");
    end
    resp = bresp;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input reg_addr_e addr, output logic [31:0] data,
                           output axil_resp_e resp);
    int unsigned waited;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    waited  = 0;
    while (!arready) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_on_error("read address was never accepted");
    end
    next_cycle();
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) stop_on_error("no read response arrived");
    end
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // table operations
  //////////////////////////////////////////////////

  // run until the buffer is full, then stop the stepper
  task automatic fill_buffer(input string name);
    int unsigned polls;
    logic [31:0] data;
    axil_resp_e  resp;
    axil_write(REG_CTRL, 32'd1, resp);
    check_resp({name, " run on"}, RESP_OKAY, resp);
    polls = 0;
    data  = '0;
    while (data[FIFO_CNT_W-1:0] != FIFO_CNT_W'(FIFO_DEPTH)) begin
      axil_read(REG_STATUS, data, resp);
      polls++;
      if (polls > MAX_POLLS) stop_on_error("buffer never reported full on status reads");
    end
    axil_write(REG_CTRL, 32'd0, resp);
    check_resp({name, " run off"}, RESP_OKAY, resp);
  endtask

  task automatic drain_words(input string name, input int unsigned n);
    logic [31:0] data;
    axil_resp_e  resp;
    rand_word_t  exp;
    for (int unsigned k = 0; k < n; k++) begin
      axil_read(REG_DATA, data, resp);
      check_resp($sformatf("%s resp %0d", name, k), RESP_OKAY, resp);
      model_advance(exp);
      check_word($sformatf("%s word %0d", name, k), exp, data[WORD_W-1:0]);
      // words come back zero-extended
      check_word($sformatf("%s high %0d", name, k), 16'h0, data[AXIL_DATA_W-1:WORD_W]);
    end
  endtask

  task automatic add_step(input op_e op, input reg_addr_e addr, input logic [31:0] data,
                          input axil_resp_e resp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.resp = resp;
    steps.push_back(s);
  endtask

  task automatic apply_step(input string name, input step_t s);
    logic [31:0] data;
    axil_resp_e  resp;
    case (s.op)
      OP_WRITE: begin
        axil_write(s.addr, s.data, resp);
        check_resp(name, s.resp, resp);
        // mirror the stepper side effects in the model
        if (s.addr == REG_SEED) model_state = s.data;
        if (s.addr == REG_ENTROPY) begin
          model_ent  = {1'b0, s.data[30:0]};
          model_pend = 1'b1;
        end
      end
      OP_READ: begin
        axil_read(s.addr, data, resp);
        check_resp(name, s.resp, resp);
        if (s.addr == REG_STATUS) begin
          check_count(name, s.data[FIFO_CNT_W-1:0], data[FIFO_CNT_W-1:0]);
        end else begin
          check_word(name, s.data[WORD_W-1:0], data[WORD_W-1:0]);
          check_word({name, " high"}, s.data[31:16], data[31:16]);
        end
      end
      OP_FILL:  fill_buffer(name);
      default:  drain_words(name, s.data);
    endcase
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    integer      rng_seed;
    logic [31:0] rand_seed;
    step_t       s;
    clk         = 1'b0;
    rst_n       = 1'b0;
    awvalid     = 1'b0;
    awaddr      = REG_CTRL;
    wvalid      = 1'b0;
    wdata       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = REG_CTRL;
    rready      = 1'b0;
    model_state = DEFAULT_SEED;
    model_ent   = '0;
    model_pend  = 1'b0;
    rng_seed    = 32'hbb05;

    // reset sequence from the default seed, then an empty read
    add_step(OP_FILL,  REG_CTRL,    32'd0, RESP_OKAY);
    add_step(OP_READ,  REG_STATUS,  FIFO_DEPTH, RESP_OKAY);
    add_step(OP_DRAIN, REG_DATA,    FIFO_DEPTH, RESP_OKAY);
    add_step(OP_READ,  REG_DATA,    32'd0, RESP_SLVERR);
    add_step(OP_READ,  REG_STATUS,  32'd0, RESP_OKAY);
    add_step(OP_READ,  REG_CTRL,    32'd0, RESP_OKAY);
    // explicit seed
    add_step(OP_WRITE, REG_SEED,    32'h1234_5678, RESP_OKAY);
    add_step(OP_FILL,  REG_CTRL,    32'd0, RESP_OKAY);
    add_step(OP_DRAIN, REG_DATA,    FIFO_DEPTH, RESP_OKAY);
    // zero seed locks up and reseeds
    add_step(OP_WRITE, REG_SEED,    32'h0, RESP_OKAY);
    add_step(OP_FILL,  REG_CTRL,    32'd0, RESP_OKAY);
    add_step(OP_DRAIN, REG_DATA,    FIFO_DEPTH, RESP_OKAY);
    // entropy touches the first step only
    add_step(OP_WRITE, REG_SEED,    32'hACE1_2468, RESP_OKAY);
    add_step(OP_WRITE, REG_ENTROPY, 32'h5A5A_F00F, RESP_OKAY);
    add_step(OP_FILL,  REG_CTRL,    32'd0, RESP_OKAY);
    add_step(OP_DRAIN, REG_DATA,    FIFO_DEPTH, RESP_OKAY);
    // read-only register ignores writes
    add_step(OP_WRITE, REG_STATUS,  32'h7, RESP_OKAY);
    add_step(OP_READ,  REG_STATUS,  32'd0, RESP_OKAY);
    add_step(OP_READ,  REG_DATA,    32'd0, RESP_SLVERR);

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    foreach (steps[i]) begin
      s = steps[i];
      apply_step($sformatf("step %0d %s", i, s.op.name()), s);
    end

    // each random seed drained in full
    for (int n = 0; n < 20; n++) begin
      rand_seed = $random(rng_seed);
      s.op   = OP_WRITE;
      s.addr = REG_SEED;
      s.data = rand_seed;
      s.resp = RESP_OKAY;
      apply_step($sformatf("seed %0d load", n), s);
      fill_buffer($sformatf("seed %0d", n));
      drain_words($sformatf("seed %0d", n), FIFO_DEPTH);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

//--- all.f
source/prng_pkg.sv
source/lfsr_stepper.sv
source/word_fifo.sv
source/axil_prng_regs.sv
source/prng_top.sv
testbench/tb_prng_top.sv
